/* common/cpu816_cfg.svh */
`ifndef CPU816_CFG_SVH
`define CPU816_CFG_SVH

// Reset vector low byte with the high byte at the next address
`define CPU816_RESET_VECTOR 16'hFFFC

`define CPU816_OP_LDA_IMM 8'hA9
`define CPU816_OP_LDX_IMM 8'hA2
`define CPU816_OP_LDY_IMM 8'hA0
`define CPU816_OP_STA_ABS 8'h8D
`define CPU816_OP_ADC_IMM 8'h69
`define CPU816_OP_TAX     8'hAA
`define CPU816_OP_TAY     8'hA8
`define CPU816_OP_TXA     8'h8A
`define CPU816_OP_TYA     8'h98
`define CPU816_OP_INX     8'hE8
`define CPU816_OP_INY     8'hC8
`define CPU816_OP_DEX     8'hCA
`define CPU816_OP_DEY     8'h88
`define CPU816_OP_CLC     8'h18
`define CPU816_OP_SEC     8'h38
`define CPU816_OP_REP     8'hC2
`define CPU816_OP_SEP     8'hE2
`define CPU816_OP_XCE     8'hFB
`define CPU816_OP_NOP     8'hEA
`define CPU816_OP_STP     8'hDB

`endif

/* common/cpu816_pkg.sv */
package cpu816Pkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] wordT;
  typedef logic [15:0] addrT;

  typedef enum logic [3:0] {
    stVectorLo,
    stVectorHi,
    stFetch,
    stOperandLo,
    stOperandHi,
    stInternal,
    stWriteLo,
    stWriteHi,
    stStopped
  } seqStateT;

  typedef enum logic [1:0] {okNone, okImmediate, okAbsStore} opKindT;
  typedef enum logic [1:0] {rsA, rsX, rsY, rsNone} regSelT;
  typedef enum logic [2:0] {aluLoad, aluAdd, aluInc, aluDec, aluTransfer} aluOpT;
  typedef enum logic [2:0] {foNone, foRep, foSep, foClc, foSec, foXce, foAlu} flagOpT;

  typedef struct packed {
    opKindT opKind;
    logic   wide;
    regSelT destSel;
    aluOpT  aluOp;
    regSelT srcSel;
    flagOpT flagOp;
    logic   isStop;
  } ctrlT;

  // we is active low
  typedef struct packed {
    addrT addr;
    byteT dataOut;
    logic vpa;
    logic vda;
    logic vpb;
    logic we;
  } busReqT;

  // Bits 7..0 follow the P register layout
  typedef struct packed {
    logic e;
    logic n;
    logic v;
    logic m;
    logic x;
    logic d;
    logic i;
    logic z;
    logic c;
  } flagsT;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } aluFlagsT;

endpackage

/* control/instr_sequencer.sv */
`timescale 1ns/1ps

module instrSequencer
(
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                rdyIn,
  input  cpu816Pkg::ctrlT     ctrl,
  input  cpu816Pkg::byteT     dataIn,
  output cpu816Pkg::seqStateT state,
  output cpu816Pkg::byteT     ir,
  output logic                advance,
  output logic                rdyOut
);
  import cpu816Pkg::*;

  seqStateT nextState;
  byteT     irReg;
  logic     resetDone;

  assign advance = rdyIn && resetDone && (state != stStopped);
  assign rdyOut  = advance;

  // The opcode being fetched decodes straight from the bus
  assign ir = (state == stFetch) ? dataIn : irReg;

  always_comb
  begin
    case (state)
      stVectorLo:  nextState = stVectorHi;
      stVectorHi:  nextState = stFetch;
      stFetch:     nextState = (ctrl.opKind == okNone) ? stInternal : stOperandLo;
      stOperandLo: nextState = (ctrl.opKind == okAbsStore || ctrl.wide) ? stOperandHi : stFetch;
      stOperandHi: nextState = (ctrl.opKind == okAbsStore) ? stWriteLo : stFetch;
      stWriteLo:   nextState = ctrl.wide ? stWriteHi : stFetch;
      stWriteHi:   nextState = stFetch;
      stInternal:  nextState = ctrl.isStop ? stStopped : stFetch;
      default:     nextState = stStopped;
    endcase
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      state     <= stVectorLo;
      irReg     <= '0;
      resetDone <= 1'b0;
    end
    else
    begin
      resetDone <= 1'b1;
      if (advance)
      begin
        state <= nextState;
        if (state == stFetch)
          irReg <= dataIn;
      end
    end
  end

  // STP is left only through reset
  assert property (@(posedge CLK) disable iff (!RST_N)
    state == stStopped |=> state == stStopped);

endmodule

/* control/opcode_decoder.sv */
`timescale 1ns/1ps
`include "cpu816_cfg.svh"

module opcodeDecoder
(
  input  cpu816Pkg::byteT  ir,
  input  cpu816Pkg::flagsT flags,
  output cpu816Pkg::ctrlT  ctrl
);
  import cpu816Pkg::*;

  logic wideA;
  logic wideX;

  function automatic ctrlT makeCtrl(opKindT kind, logic isWide, regSelT dest,
                                    aluOpT op, regSelT src, flagOpT flag);
    return '{opKind: kind, wide: isWide, destSel: dest, aluOp: op,
             srcSel: src, flagOp: flag, isStop: 1'b0};
  endfunction

  // Emulation mode is always 8-bit
  assign wideA = !flags.m && !flags.e;
  assign wideX = !flags.x && !flags.e;

  always_comb
  begin
    case (ir)
      `CPU816_OP_LDA_IMM: ctrl = makeCtrl(okImmediate, wideA, rsA, aluLoad, rsA, foAlu);
      `CPU816_OP_LDX_IMM: ctrl = makeCtrl(okImmediate, wideX, rsX, aluLoad, rsA, foAlu);
      `CPU816_OP_LDY_IMM: ctrl = makeCtrl(okImmediate, wideX, rsY, aluLoad, rsA, foAlu);
      `CPU816_OP_ADC_IMM: ctrl = makeCtrl(okImmediate, wideA, rsA, aluAdd, rsA, foAlu);
      `CPU816_OP_STA_ABS: ctrl = makeCtrl(okAbsStore, wideA, rsNone, aluLoad, rsA, foNone);
      `CPU816_OP_TAX:     ctrl = makeCtrl(okNone, wideX, rsX, aluTransfer, rsA, foAlu);
      `CPU816_OP_TAY:     ctrl = makeCtrl(okNone, wideX, rsY, aluTransfer, rsA, foAlu);
      `CPU816_OP_TXA:     ctrl = makeCtrl(okNone, wideA, rsA, aluTransfer, rsX, foAlu);
      `CPU816_OP_TYA:     ctrl = makeCtrl(okNone, wideA, rsA, aluTransfer, rsY, foAlu);
      `CPU816_OP_INX:     ctrl = makeCtrl(okNone, wideX, rsX, aluInc, rsX, foAlu);
      `CPU816_OP_INY:     ctrl = makeCtrl(okNone, wideX, rsY, aluInc, rsY, foAlu);
      `CPU816_OP_DEX:     ctrl = makeCtrl(okNone, wideX, rsX, aluDec, rsX, foAlu);
      `CPU816_OP_DEY:     ctrl = makeCtrl(okNone, wideX, rsY, aluDec, rsY, foAlu);
      `CPU816_OP_CLC:     ctrl = makeCtrl(okNone, 1'b0, rsNone, aluLoad, rsA, foClc);
      `CPU816_OP_SEC:     ctrl = makeCtrl(okNone, 1'b0, rsNone, aluLoad, rsA, foSec);
      `CPU816_OP_XCE:     ctrl = makeCtrl(okNone, 1'b0, rsNone, aluLoad, rsA, foXce);
      // REP and SEP always take a one-byte mask
      `CPU816_OP_REP:     ctrl = makeCtrl(okImmediate, 1'b0, rsNone, aluLoad, rsA, foRep);
      `CPU816_OP_SEP:     ctrl = makeCtrl(okImmediate, 1'b0, rsNone, aluLoad, rsA, foSep);
      `CPU816_OP_NOP, `CPU816_OP_STP:
        ctrl = makeCtrl(okNone, 1'b0, rsNone, aluLoad, rsA, foNone);
      default:            ctrl = makeCtrl(okNone, 1'b0, rsNone, aluLoad, rsA, foNone);
    endcase
    ctrl.isStop = (ir == `CPU816_OP_STP);
  end

endmodule

/* datapath/register_alu.sv */
`timescale 1ns/1ps

module registerAlu
(
  input  logic                CLK,
  input  logic                RST_N,
  input  cpu816Pkg::ctrlT     ctrl,
  input  logic                advance,
  input  cpu816Pkg::seqStateT state,
  input  cpu816Pkg::wordT     operand,
  input  cpu816Pkg::flagsT    flags,
  output cpu816Pkg::byteT     accLow,
  output cpu816Pkg::byteT     accHigh,
  output cpu816Pkg::aluFlagsT aluFlags
);
  import cpu816Pkg::*;

  wordT        regA;
  wordT        regX;
  wordT        regY;
  wordT        srcVal;
  wordT        destVal;
  wordT        result;
  logic [8:0]  sum8;
  logic [16:0] sum16;
  logic        commit;

  assign commit = advance && ((state == stInternal) || (ctrl.opKind == okImmediate &&
                  (state == stOperandHi || (state == stOperandLo && !ctrl.wide))));

  assign srcVal  = (ctrl.srcSel == rsX) ? regX : (ctrl.srcSel == rsY) ? regY : regA;
  assign destVal = (ctrl.destSel == rsX) ? regX : (ctrl.destSel == rsY) ? regY : regA;

  // Binary add only
  assign sum8  = {1'b0, regA[7:0]} + {1'b0, operand[7:0]} + 9'(flags.c);
  assign sum16 = {1'b0, regA} + {1'b0, operand} + 17'(flags.c);

  always_comb
  begin
    case (ctrl.aluOp)
      aluAdd:      result = ctrl.wide ? sum16[15:0] : {8'h00, sum8[7:0]};
      aluInc:      result = destVal + 16'd1;
      aluDec:      result = destVal - 16'd1;
      aluTransfer: result = srcVal;
      default:     result = operand;
    endcase
  end

  always_comb
  begin
    if (ctrl.wide)
    begin
      aluFlags.n = result[15];
      aluFlags.z = (result == 16'h0000);
      aluFlags.c = sum16[16];
      aluFlags.v = (regA[15] == operand[15]) && (result[15] != regA[15]);
    end
    else
    begin
      aluFlags.n = result[7];
      aluFlags.z = (result[7:0] == 8'h00);
      aluFlags.c = sum8[8];
      aluFlags.v = (regA[7] == operand[7]) && (result[7] != regA[7]);
    end
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      regA <= '0;
      regX <= '0;
      regY <= '0;
    end
    else
    begin
      if (commit)
      begin
        case (ctrl.destSel)
          rsA: regA <= ctrl.wide ? result : {regA[15:8], result[7:0]};
          rsX: regX <= ctrl.wide ? result : {regX[15:8], result[7:0]};
          rsY: regY <= ctrl.wide ? result : {regY[15:8], result[7:0]};
          default: ;
        endcase
      end
      // 8-bit index mode has no high byte
      if (flags.x)
      begin
        regX[15:8] <= 8'h00;
        regY[15:8] <= 8'h00;
      end
    end
  end

  assign accLow  = regA[7:0];
  assign accHigh = regA[15:8];

endmodule

/* datapath/status_register.sv */
`timescale 1ns/1ps

module statusRegister
(
  input  logic                CLK,
  input  logic                RST_N,
  input  cpu816Pkg::ctrlT     ctrl,
  input  logic                advance,
  input  cpu816Pkg::seqStateT state,
  input  cpu816Pkg::wordT     operand,
  input  cpu816Pkg::aluFlagsT aluFlags,
  output cpu816Pkg::flagsT    flags
);
  import cpu816Pkg::*;

  logic commit;
  byteT mask;

  assign commit = advance && ((state == stInternal) || (ctrl.opKind == okImmediate &&
                  (state == stOperandHi || (state == stOperandLo && !ctrl.wide))));

  // M and X cannot be touched by REP/SEP in emulation mode
  assign mask = {operand[7:6], operand[5] & !flags.e, operand[4] & !flags.e, operand[3:0]};

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      flags <= '{e: 1'b1, n: 1'b0, v: 1'b0, m: 1'b1, x: 1'b1,
                 d: 1'b0, i: 1'b1, z: 1'b0, c: 1'b0};
    else if (commit)
    begin
      case (ctrl.flagOp)
        foRep: flags[7:0] <= flags[7:0] & ~mask;
        foSep: flags[7:0] <= flags[7:0] | mask;
        foClc: flags.c <= 1'b0;
        foSec: flags.c <= 1'b1;
        foXce:
        begin
          flags.e <= flags.c;
          flags.c <= flags.e;
          // entering emulation
          if (flags.c)
          begin
            flags.m <= 1'b1;
            flags.x <= 1'b1;
          end
        end
        foAlu:
        begin
          flags.n <= aluFlags.n;
          flags.z <= aluFlags.z;
          if (ctrl.aluOp == aluAdd)
          begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* design/bus_interface.sv */
`timescale 1ns/1ps
`include "cpu816_cfg.svh"

module busInterface
(
  input  logic                CLK,
  input  logic                RST_N,
  input  cpu816Pkg::seqStateT state,
  input  logic                advance,
  input  cpu816Pkg::byteT     dataIn,
  input  cpu816Pkg::byteT     accLow,
  input  cpu816Pkg::byteT     accHigh,
  output cpu816Pkg::wordT     operand,
  output cpu816Pkg::busReqT   busOut
);
  import cpu816Pkg::*;

  localparam addrT vectorAddr = `CPU816_RESET_VECTOR;

  addrT pc;
  wordT opLatch;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      pc <= '0;
    else if (advance)
    begin
      case (state)
        stVectorLo: pc[7:0] <= dataIn;
        stVectorHi: pc[15:8] <= dataIn;
        stFetch, stOperandLo, stOperandHi: pc <= pc + 16'd1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (advance && state == stOperandLo)
      opLatch[7:0] <= dataIn;
    if (advance && state == stOperandHi)
      opLatch[15:8] <= dataIn;
  end

  // Forward the byte on the bus so the last operand cycle can commit
  always_comb
  begin
    case (state)
      stOperandLo: operand = {opLatch[15:8], dataIn};
      stOperandHi: operand = {dataIn, opLatch[7:0]};
      default:     operand = opLatch;
    endcase
  end

  always_comb
  begin
    busOut.addr    = pc;
    busOut.dataOut = '0;
    busOut.vpa     = 1'b0;
    busOut.vda     = 1'b0;
    busOut.vpb     = 1'b1;
    busOut.we      = 1'b1;
    case (state)
      stVectorLo, stVectorHi:
      begin
        busOut.addr = (state == stVectorHi) ? vectorAddr + 16'd1 : vectorAddr;
        busOut.vda  = 1'b1;
        busOut.vpb  = 1'b0;
      end
      stFetch, stOperandLo, stOperandHi:
      begin
        busOut.vpa = 1'b1;
        busOut.vda = 1'b1;
      end
      stWriteLo, stWriteHi:
      begin
        busOut.addr    = (state == stWriteHi) ? opLatch + 16'd1 : opLatch;
        busOut.dataOut = (state == stWriteHi) ? accHigh : accLow;
        busOut.vda     = 1'b1;
        busOut.we      = 1'b0;
      end
      default: ;
    endcase
  end

  // Writes only come straight out of the operand fetch of a store
  assert property (@(posedge CLK) disable iff (!RST_N)
    !busOut.we |-> $past(state) inside {stOperandHi, stWriteLo, stWriteHi});

  // A stalled cycle repeats unchanged
  assert property (@(posedge CLK) disable iff (!RST_N)
    !advance |=> $stable(busOut));

endmodule

/* design/cpu816_top.sv */
`timescale 1ns/1ps

module cpu816Top
(
  input  logic              CLK,
  input  logic              RST_N,
  input  cpu816Pkg::byteT   dataIn,
  input  logic              rdyIn,
  output cpu816Pkg::busReqT busOut,
  output logic              rdyOut
);
  import cpu816Pkg::*;

  seqStateT state;
  byteT     ir;
  logic     advance;
  ctrlT     ctrl;
  flagsT    flags;
  wordT     operand;
  byteT     accLow;
  byteT     accHigh;
  aluFlagsT aluFlags;

  instrSequencer sequencer (
    .CLK(CLK), .RST_N(RST_N), .rdyIn(rdyIn), .ctrl(ctrl), .dataIn(dataIn),
    .state(state), .ir(ir), .advance(advance), .rdyOut(rdyOut)
  );

  opcodeDecoder decoder (.ir(ir), .flags(flags), .ctrl(ctrl));

  busInterface busUnit (
    .CLK(CLK), .RST_N(RST_N), .state(state), .advance(advance), .dataIn(dataIn),
    .accLow(accLow), .accHigh(accHigh), .operand(operand), .busOut(busOut)
  );

  registerAlu regAlu (
    .CLK(CLK), .RST_N(RST_N), .ctrl(ctrl), .advance(advance), .state(state),
    .operand(operand), .flags(flags), .accLow(accLow), .accHigh(accHigh),
    .aluFlags(aluFlags)
  );

  statusRegister statusReg (
    .CLK(CLK), .RST_N(RST_N), .ctrl(ctrl), .advance(advance), .state(state),
    .operand(operand), .aluFlags(aluFlags), .flags(flags)
  );

endmodule

/* tb/tb_cpu816.sv */
`timescale 1ns/1ps
`include "cpu816_cfg.svh"

module tbCpu816;
  import cpu816Pkg::*;

  localparam addrT progStart  = 16'h0200;
  localparam byteT emuVal     = 8'h35;
  localparam wordT nativeVal  = 16'h1234;
  localparam wordT indexVal   = 16'hABFF;
  localparam int   baseCycles = 49;
  localparam int   cycleLimit = 4 * baseCycles;
  localparam int   numTests   = 6;

  logic   CLK;
  logic   RST_N;
  logic   rdyIn;
  logic   rdyOut;
  byteT   dataIn;
  busReqT busOut;

  byteT  mem [0:65535];
  addrT  expAddr [0:15];
  byteT  expData [0:15];
  int    expTest [0:15];
  int    lastWriteOf [0:numTests-1];
  string testName [0:numTests-1];
  int    testErr [0:numTests-1];
  logic  reported [0:numTests-1];
  int    nExp;
  int    writeIdx;
  int    cycleNum;
  int    stopCycles;
  logic  stpFetched;
  int    errors;
  int    cycles;
  int    failedTests;
  logic  timedOut;
  addrT  loadPtr;

  cpu816Top uut (
    .CLK(CLK), .RST_N(RST_N), .dataIn(dataIn), .rdyIn(rdyIn),
    .busOut(busOut), .rdyOut(rdyOut)
  );

  assign dataIn = mem[busOut.addr];

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Random back-pressure holds rdyIn low one cycle in four
  initial
  begin
    rdyIn = 1'b0;
    void'($urandom(32'h806a_b0d3));
    forever
    begin
      @(posedge CLK);
      rdyIn <= ($urandom() % 4) != 0;
    end
  end

  task automatic emit(input byteT b);
    mem[loadPtr] = b;
    loadPtr = loadPtr + 16'd1;
  endtask

  task automatic emitStore(input addrT a);
    emit(`CPU816_OP_STA_ABS);
    emit(a[7:0]);
    emit(a[15:8]);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 65536; i++)
      mem[i] = byteT'(i[15:8] ^ i[7:0] ^ 8'h5A);
    mem[`CPU816_RESET_VECTOR] = progStart[7:0];
    mem[`CPU816_RESET_VECTOR + 1] = progStart[15:8];
    loadPtr = progStart;
    // 8-bit add with carry in emulation mode
    emit(`CPU816_OP_SEC);
    emit(`CPU816_OP_LDA_IMM);
    emit(emuVal);
    emit(`CPU816_OP_ADC_IMM);
    emit(emuVal);
    emitStore(16'h1000);
    // 16-bit accumulator in native mode
    emit(`CPU816_OP_CLC);
    emit(`CPU816_OP_XCE);
    emit(`CPU816_OP_REP);
    emit(8'h30);
    emit(`CPU816_OP_LDA_IMM);
    emit(nativeVal[7:0]);
    emit(nativeVal[15:8]);
    emitStore(16'h1010);
    // Index narrowing and transfers
    emit(`CPU816_OP_LDX_IMM);
    emit(indexVal[7:0]);
    emit(indexVal[15:8]);
    emit(`CPU816_OP_SEP);
    emit(8'h10);
    emit(`CPU816_OP_TXA);
    emitStore(16'h1020);
    emit(`CPU816_OP_INX);
    emit(`CPU816_OP_TXA);
    emitStore(16'h1030);
    emit(`CPU816_OP_STP);
  endtask

  task automatic addWrite(input addrT a, input byteT d, input int t);
    expAddr[nExp] = a;
    expData[nExp] = d;
    expTest[nExp] = t;
    lastWriteOf[t] = nExp;
    nExp++;
  endtask

  task automatic buildExpected();
    wordT x;
    byteT sum;
    nExp = 0;
    for (int t = 0; t < numTests; t++)
      lastWriteOf[t] = -1;
    // SEC sets the carry and emulation keeps A at 8 bits
    sum = byteT'(emuVal + emuVal + 8'd1);
    addWrite(16'h1000, sum, 1);
    addWrite(16'h1010, nativeVal[7:0], 2);
    addWrite(16'h1011, nativeVal[15:8], 2);
    // SEP #$10 drops the X high byte
    // TXA stays 16 bits while M is clear
    x = {8'h00, indexVal[7:0]};
    addWrite(16'h1020, x[7:0], 3);
    addWrite(16'h1021, x[15:8], 3);
    x = {8'h00, byteT'(x[7:0] + 8'd1)};
    addWrite(16'h1030, x[7:0], 3);
    addWrite(16'h1031, x[15:8], 3);
  endtask

  task automatic reportTest(input int t);
    $display("test %s finished, %0d errors", testName[t], testErr[t]);
  endtask

  always @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      writeIdx   <= 0;
      cycleNum   <= 0;
      stopCycles <= 0;
      stpFetched <= 1'b0;
    end
    else if (rdyOut)
    begin
      cycleNum <= cycleNum + 1;
      if (!busOut.we)
        writeIdx <= writeIdx + 1;
      if (busOut.vpa && busOut.vda && dataIn == `CPU816_OP_STP)
        stpFetched <= 1'b1;
      if (stpFetched)
        stopCycles <= stopCycles + 1;
    end
  end

  // Bus tests are reported half a cycle after their last checked edge
  always @(negedge CLK)
  begin
    if (!RST_N)
    begin
      for (int t = 0; t < numTests; t++)
        reported[t] <= 1'b0;
    end
    else
    begin
      if (!reported[0] && cycleNum > 2)
      begin
        reportTest(0);
        reported[0] <= 1'b1;
      end
      for (int t = 1; t < numTests; t++)
        if (!reported[t] && lastWriteOf[t] >= 0 && writeIdx > lastWriteOf[t])
        begin
          reportTest(t);
          reported[t] <= 1'b1;
        end
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && cycleNum < 2 |-> busOut.addr == addrT'(`CPU816_RESET_VECTOR + cycleNum))
  else
  begin
    $display("CHECK FAILED %s: expected %h, actual %h", testName[0],
             addrT'(`CPU816_RESET_VECTOR + $sampled(cycleNum)), $sampled(busOut.addr));
    errors++;
    testErr[0]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && cycleNum < 2 |-> !busOut.vpb && busOut.vda && !busOut.vpa)
  else
  begin
    $display("%s: vector read without VPB low and VDA-only strobes", testName[0]);
    errors++;
    testErr[0]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && cycleNum == 2 |-> busOut.addr == progStart && busOut.vpa && busOut.vda)
  else
  begin
    $display("CHECK FAILED %s: expected %h, actual %h", testName[0],
             progStart, $sampled(busOut.addr));
    errors++;
    testErr[0]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && !busOut.we && writeIdx < nExp |-> busOut.addr == expAddr[writeIdx])
  else
  begin
    $display("CHECK FAILED %s: expected %h, actual %h", testName[expTest[$sampled(writeIdx)]],
             expAddr[$sampled(writeIdx)], $sampled(busOut.addr));
    errors++;
    testErr[expTest[$sampled(writeIdx)]]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && !busOut.we && writeIdx < nExp |-> busOut.dataOut == expData[writeIdx])
  else
  begin
    $display("CHECK FAILED %s: expected %h, actual %h", testName[expTest[$sampled(writeIdx)]],
             expData[$sampled(writeIdx)], $sampled(busOut.dataOut));
    errors++;
    testErr[expTest[$sampled(writeIdx)]]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut && !busOut.we |-> writeIdx < nExp)
  else
  begin
    $display("%s: write beyond the expected list", testName[4]);
    errors++;
    testErr[4]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N) !rdyIn |-> !rdyOut)
  else
  begin
    $display("%s: rdyOut high while rdyIn low", testName[4]);
    errors++;
    testErr[4]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N) !rdyIn |=> $stable(busOut))
  else
  begin
    $display("%s: bus changed during a stalled cycle", testName[4]);
    errors++;
    testErr[4]++;
  end

  assert property (@(posedge CLK) disable iff (!RST_N)
    stopCycles != 0 |-> !busOut.vpa && !busOut.vda && !rdyOut)
  else
  begin
    $display("%s: core still active after STP", testName[5]);
    errors++;
    testErr[5]++;
  end

  initial
  begin
    RST_N    = 1'b0;
    errors   = 0;
    cycles   = 0;
    timedOut = 1'b0;
    testName = '{"resetVector", "emulation8", "native16", "indexWidth", "stall", "stp"};
    for (int t = 0; t < numTests; t++)
      testErr[t] = 0;
    loadProgram();
    buildExpected();
    repeat (5) @(posedge CLK);
    RST_N <= 1'b1;
    while (stopCycles == 0 && cycles < cycleLimit)
    begin
      @(posedge CLK);
      cycles++;
    end
    if (stopCycles == 0)
    begin
      $display("Timeout: core did not halt within %0d cycles", cycleLimit);
      timedOut = 1'b1;
    end
    else
      repeat (20) @(posedge CLK);
    @(negedge CLK);
    #1;
    assert (writeIdx == nExp)
    else
    begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", testName[4], nExp, writeIdx);
      errors++;
      testErr[4]++;
    end
    for (int t = 0; t < numTests; t++)
      if (!reported[t])
        reportTest(t);
    failedTests = 0;
    for (int t = 0; t < numTests; t++)
      if (testErr[t] != 0)
        failedTests++;
    $display("Tests: %0d passed, %0d failed, %0d errors", numTests - failedTests,
             failedTests, errors);
    if (errors == 0 && !timedOut)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* sim.f */
+incdir+common
common/cpu816_pkg.sv
control/instr_sequencer.sv
control/opcode_decoder.sv
datapath/register_alu.sv
datapath/status_register.sv
design/bus_interface.sv
design/cpu816_top.sv
tb/tb_cpu816.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbCpu816 -f sim.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
